// File: logic/rta_macros.svh
// Depths and Wishbone word-address map for the ray-cast slice
`ifndef RTA_MACROS_SVH
`define RTA_MACROS_SVH

// ======================================================================
// Memory depths
// ======================================================================

// Triangle slots, one bounding box each
`define RTA_TRI_DEPTH 64

// Pixels in a 16 x 16 image
`define RTA_PIX_DEPTH 256

// ======================================================================
// Word addresses on the host bus
// ======================================================================

`define RTA_ADR_CTRL      10'h000
`define RTA_ADR_STATUS    10'h001
`define RTA_ADR_PIX_COUNT 10'h002
`define RTA_ADR_TRI_COUNT 10'h003

// Memory windows
`define RTA_ADR_TRI_BASE  10'h100
`define RTA_ADR_RES_BASE  10'h200

`endif

// File: logic/rta_pkg.sv
// Shared types for the ray-cast slice
// Bus words, ids, and the job, triangle and hit records
`include "rta_macros.svh"

package rta_pkg;

  // ====================================================================
  // Plain vectors
  // ====================================================================

  // Wishbone data and word address
  typedef logic [31:0] word_t;
  typedef logic [9:0]  wb_adr_t;

  // Ids sized from the memory depths
  typedef logic [$clog2(`RTA_PIX_DEPTH)-1:0] pixel_id_t;
  typedef logic [$clog2(`RTA_TRI_DEPTH)-1:0] tri_id_t;

  // Screen coordinate, unsigned
  typedef logic [7:0] coord_t;

  // One bit wider than a pixel id so a full image count fits
  typedef logic [$clog2(`RTA_PIX_DEPTH):0] count_t;

  // ====================================================================
  // Records
  // ====================================================================

  // Screen bounding box, x_min in the top byte of the host word
  typedef struct packed {
    coord_t x_min;
    coord_t x_max;
    coord_t y_min;
    coord_t y_max;
  } triangle_t;

  // One pixel to scan, with the triangle count taken at go
  typedef struct packed {
    pixel_id_t pixel_id;
    count_t    tri_count;
  } pixel_job_t;

  // Per-pixel result, hit lands in bit 6 of the read word
  typedef struct packed {
    logic    hit;
    tri_id_t tri_id;
  } hit_t;

  // Scan FSM
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    TEST,
    WRITE
  } scan_state_t;

endpackage

// File: logic/mmio_wb_slave.sv
// Wishbone classic register block for the ray-cast slice
// Holds config and status, and the host ports into both memories
`include "rta_macros.svh"

module mmio_wb_slave (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               cyc,
  input  logic               stb,
  input  logic               we,
  input  rta_pkg::wb_adr_t   adr,
  input  rta_pkg::word_t     dat_w,
  input  logic               last_done,
  input  rta_pkg::hit_t      res_rd_data,
  output rta_pkg::word_t     dat_r,
  output logic               ack,
  output logic               go,
  output logic               tri_we,
  output rta_pkg::tri_id_t   tri_wr_addr,
  output rta_pkg::triangle_t tri_wr_data,
  output rta_pkg::pixel_id_t res_rd_addr,
  output rta_pkg::count_t    pix_count,
  output rta_pkg::count_t    tri_count
);

  logic busy;
  logic done;
  logic wr_cyc;
  logic in_tri;
  logic in_res;

  // Window decode
  assign in_tri = (adr >= `RTA_ADR_TRI_BASE) && (adr < `RTA_ADR_TRI_BASE + `RTA_TRI_DEPTH);
  assign in_res = (adr >= `RTA_ADR_RES_BASE) && (adr < `RTA_ADR_RES_BASE + `RTA_PIX_DEPTH);

  // One-cycle ack followed by one idle cycle before the next
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= cyc & stb & ~ack;
    end
  end

  // Writes land on the ack cycle
  assign wr_cyc = ack & cyc & stb & we;

  // Start only from an idle engine
  assign go = wr_cyc && (adr == `RTA_ADR_CTRL) && dat_w[0] && !busy;

  // Triangle write port carries one box per word
  assign tri_we      = wr_cyc & in_tri;
  assign tri_wr_addr = rta_pkg::tri_id_t'(adr - `RTA_ADR_TRI_BASE);
  assign tri_wr_data = rta_pkg::triangle_t'(dat_w);

  // Result read address presented while the request waits for ack
  assign res_rd_addr = rta_pkg::pixel_id_t'(adr - `RTA_ADR_RES_BASE);

  // ====================================================================
  // Config and status
  // ====================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_count <= '0;
      tri_count <= '0;
      busy      <= 1'b0;
      done      <= 1'b0;
    end else begin
      if (wr_cyc && (adr == `RTA_ADR_PIX_COUNT)) begin
        pix_count <= rta_pkg::count_t'(dat_w);
      end
      if (wr_cyc && (adr == `RTA_ADR_TRI_COUNT)) begin
        tri_count <= rta_pkg::count_t'(dat_w);
      end
      // Empty run finishes on the spot
      if (go) begin
        busy <= (pix_count != '0);
        done <= (pix_count == '0);
      end else if (last_done) begin
        busy <= 1'b0;
        done <= 1'b1;
      end
    end
  end

  // Read mux with unmapped words reading zero
  always_comb begin
    dat_r = '0;
    if (in_res) begin
      dat_r = rta_pkg::word_t'(res_rd_data);
    end else begin
      case (adr)
        `RTA_ADR_STATUS:    dat_r = {30'b0, done, busy};
        `RTA_ADR_PIX_COUNT: dat_r = rta_pkg::word_t'(pix_count);
        `RTA_ADR_TRI_COUNT: dat_r = rta_pkg::word_t'(tri_count);
        default:            dat_r = '0;
      endcase
    end
  end

  // Ack only while the master still holds its request
  assert property (@(posedge clk) disable iff (!rst_n)
    ack |-> (cyc && stb));

  // Final result write only arrives during a run
  assert property (@(posedge clk) disable iff (!rst_n)
    last_done |-> busy);

endmodule

// File: logic/command_processor.sv
// Command processor, turns go and a pixel count into pixel jobs
// Keeps one job registered ahead of the scan stage

module command_processor (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                go,
  input  rta_pkg::count_t     pix_count,
  input  rta_pkg::count_t     tri_count,
  input  logic                job_ready,
  output rta_pkg::pixel_job_t job,
  output logic                job_valid
);

  // Id of the job after the one on offer
  rta_pkg::count_t next_id;
  // Pixel count frozen at go
  rta_pkg::count_t pix_total;
  logic            start;
  logic            take;

  // Go mid-run is dropped, zero pixels makes no jobs
  assign start = go && !job_valid && (pix_count != '0);
  assign take  = job_valid & job_ready;

  // ====================================================================
  // Job sequencing
  // ====================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      job_valid <= 1'b0;
      next_id   <= '0;
    end else if (start) begin
      job_valid <= 1'b1;
      next_id   <= rta_pkg::count_t'(1);
    end else if (take) begin
      // Last id consumed
      if (next_id == pix_total) begin
        job_valid <= 1'b0;
      end else begin
        next_id <= next_id + 1'b1;
      end
    end
  end

  // Job payload, held while the scan stalls
  always_ff @(posedge clk) begin
    if (start) begin
      pix_total     <= pix_count;
      job.pixel_id  <= '0;
      job.tri_count <= tri_count;
    end else if (take && (next_id != pix_total)) begin
      job.pixel_id  <= rta_pkg::pixel_id_t'(next_id);
    end
  end

endmodule

// File: logic/mem_triangle.sv
// Triangle bounding-box memory
// Host writes one box per word, scan reads with one cycle latency
`include "rta_macros.svh"

module mem_triangle (
  input  logic               clk,
  input  logic               tri_we,
  input  rta_pkg::tri_id_t   tri_wr_addr,
  input  rta_pkg::triangle_t tri_wr_data,
  input  logic               tri_rd_en,
  input  rta_pkg::tri_id_t   tri_rd_addr,
  output rta_pkg::triangle_t tri_rd_data
);

  // Box storage
  rta_pkg::triangle_t mem [`RTA_TRI_DEPTH];

  // Host side write
  always_ff @(posedge clk) begin
    if (tri_we) begin
      mem[tri_wr_addr] <= tri_wr_data;
    end
  end

  // Registered read, holds when idle
  always_ff @(posedge clk) begin
    if (tri_rd_en) begin
      tri_rd_data <= mem[tri_rd_addr];
    end
  end

endmodule

// File: logic/tri_scan.sv
// Triangle scan that walks all boxes for one pixel and keeps the first hit
// One fetch per cycle with the result written two cycles after the last fetch

module tri_scan (
  input  logic                clk,
  input  logic                rst_n,
  input  rta_pkg::pixel_job_t job,
  input  logic                job_valid,
  input  rta_pkg::count_t     pix_count,
  input  rta_pkg::triangle_t  tri_rd_data,
  output logic                job_ready,
  output logic                tri_rd_en,
  output rta_pkg::tri_id_t    tri_rd_addr,
  output logic                res_we,
  output rta_pkg::pixel_id_t  res_addr,
  output rta_pkg::hit_t       res_data,
  output logic                last_done
);

  rta_pkg::scan_state_t state;
  rta_pkg::pixel_job_t  cur_job;
  rta_pkg::count_t      fetch_cnt;
  // Read data valid this cycle and its triangle id
  logic                 rd_pending;
  rta_pkg::tri_id_t     rd_id;
  rta_pkg::hit_t        hit_r;
  rta_pkg::coord_t      px;
  rta_pkg::coord_t      py;
  logic                 covered;
  logic                 accept;

  assign job_ready = (state == rta_pkg::IDLE);
  assign accept    = job_valid & job_ready;

  assign tri_rd_en   = (state == rta_pkg::FETCH);
  assign tri_rd_addr = rta_pkg::tri_id_t'(fetch_cnt);

  // 16 wide image with x in the low nibble
  assign px = rta_pkg::coord_t'(cur_job.pixel_id[3:0]);
  assign py = rta_pkg::coord_t'(cur_job.pixel_id[7:4]);

  // Inclusive unsigned box test
  assign covered = rd_pending &&
                   (px >= tri_rd_data.x_min) && (px <= tri_rd_data.x_max) &&
                   (py >= tri_rd_data.y_min) && (py <= tri_rd_data.y_max);

  // Result port
  assign res_we    = (state == rta_pkg::WRITE);
  assign res_addr  = cur_job.pixel_id;
  assign res_data  = hit_r;
  assign last_done = res_we && (rta_pkg::count_t'(cur_job.pixel_id) + 1'b1 == pix_count);

  // ====================================================================
  // Scan FSM
  // ====================================================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= rta_pkg::IDLE;
      fetch_cnt  <= '0;
      rd_pending <= 1'b0;
      hit_r      <= '0;
    end else begin
      rd_pending <= tri_rd_en;
      case (state)
        rta_pkg::IDLE: begin
          if (accept) begin
            fetch_cnt <= '0;
            hit_r     <= '0;
            // No triangles means a straight miss
            state     <= (job.tri_count == '0) ? rta_pkg::TEST : rta_pkg::FETCH;
          end
        end
        rta_pkg::FETCH: begin
          fetch_cnt <= fetch_cnt + 1'b1;
          if (fetch_cnt + 1'b1 == cur_job.tri_count) begin
            state <= rta_pkg::TEST;
          end
        end
        // Last read data tested here
        rta_pkg::TEST:  state <= rta_pkg::WRITE;
        rta_pkg::WRITE: state <= rta_pkg::IDLE;
        default:        state <= rta_pkg::IDLE;
      endcase
      // Boxes come in id order so the first hit is the lowest
      if (covered && !hit_r.hit) begin
        hit_r <= '{hit: 1'b1, tri_id: rd_id};
      end
    end
  end

  // Job copy and read-id tracking
  always_ff @(posedge clk) begin
    if (accept) begin
      cur_job <= job;
    end
    rd_id <= tri_rd_addr;
  end

  // Offered job stays put while the scan is busy
  assert property (@(posedge clk) disable iff (!rst_n)
    (job_valid && !job_ready) |=> (job_valid && $stable(job)));

  // A hit names a triangle within the job's count
  assert property (@(posedge clk) disable iff (!rst_n)
    (res_we && res_data.hit) |-> (rta_pkg::count_t'(res_data.tri_id) < cur_job.tri_count));

endmodule

// File: logic/mem_result.sv
// Per-pixel hit memory
// Scan writes, host reads through a registered port
`include "rta_macros.svh"

module mem_result (
  input  logic               clk,
  input  logic               res_we,
  input  rta_pkg::pixel_id_t res_addr,
  input  rta_pkg::hit_t      res_data,
  input  rta_pkg::pixel_id_t res_rd_addr,
  output rta_pkg::hit_t      res_rd_data
);

  // One hit record per pixel
  rta_pkg::hit_t mem [`RTA_PIX_DEPTH];

  // Scan side write, old results stay until overwritten
  always_ff @(posedge clk) begin
    if (res_we) begin
      mem[res_addr] <= res_data;
    end
  end

  // Host read, data ready on the ack cycle
  always_ff @(posedge clk) begin
    res_rd_data <= mem[res_rd_addr];
  end

endmodule

// File: logic/rta.sv
// Ray-cast slice top level
// Wishbone slave beside a command, scan and result pipeline

module rta (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  rta_pkg::wb_adr_t adr,
  input  rta_pkg::word_t   dat_w,
  output rta_pkg::word_t   dat_r,
  output logic             ack
);

  // Slave to pipeline
  logic                go;
  logic                last_done;
  rta_pkg::count_t     pix_count;
  rta_pkg::count_t     tri_count;
  // Triangle memory ports
  logic                tri_we;
  rta_pkg::tri_id_t    tri_wr_addr;
  rta_pkg::triangle_t  tri_wr_data;
  logic                tri_rd_en;
  rta_pkg::tri_id_t    tri_rd_addr;
  rta_pkg::triangle_t  tri_rd_data;
  // Job handshake
  rta_pkg::pixel_job_t job;
  logic                job_valid;
  logic                job_ready;
  // Result memory ports
  logic                res_we;
  rta_pkg::pixel_id_t  res_addr;
  rta_pkg::hit_t       res_data;
  rta_pkg::pixel_id_t  res_rd_addr;
  rta_pkg::hit_t       res_rd_data;

  mmio_wb_slave slave_inst (
    .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .last_done(last_done), .res_rd_data(res_rd_data),
    .dat_r(dat_r), .ack(ack), .go(go), .tri_we(tri_we),
    .tri_wr_addr(tri_wr_addr), .tri_wr_data(tri_wr_data),
    .res_rd_addr(res_rd_addr), .pix_count(pix_count), .tri_count(tri_count)
  );

  command_processor cp_inst (
    .clk(clk), .rst_n(rst_n), .go(go), .pix_count(pix_count),
    .tri_count(tri_count), .job_ready(job_ready), .job(job), .job_valid(job_valid)
  );

  mem_triangle tri_mem_inst (
    .clk(clk), .tri_we(tri_we), .tri_wr_addr(tri_wr_addr),
    .tri_wr_data(tri_wr_data), .tri_rd_en(tri_rd_en),
    .tri_rd_addr(tri_rd_addr), .tri_rd_data(tri_rd_data)
  );

  tri_scan scan_inst (
    .clk(clk), .rst_n(rst_n), .job(job), .job_valid(job_valid),
    .pix_count(pix_count), .tri_rd_data(tri_rd_data), .job_ready(job_ready),
    .tri_rd_en(tri_rd_en), .tri_rd_addr(tri_rd_addr), .res_we(res_we),
    .res_addr(res_addr), .res_data(res_data), .last_done(last_done)
  );

  mem_result res_mem_inst (
    .clk(clk), .res_we(res_we), .res_addr(res_addr), .res_data(res_data),
    .res_rd_addr(res_rd_addr), .res_rd_data(res_rd_data)
  );

endmodule

// File: verification/rta_tb_model.svh
// Testbench model for the ray-cast slice
// Random source, scene and result shadows, and typed compare tasks
`ifndef RTA_TB_MODEL_SVH
`define RTA_TB_MODEL_SVH

// ======================================================================
// Random source and shadow state
// ======================================================================

rta_pkg::word_t     lfsr_state = 32'h6513_6a59;
rta_pkg::triangle_t tri_model [`RTA_TRI_DEPTH];
rta_pkg::hit_t      res_model [`RTA_PIX_DEPTH];
string              cur_test;
int                 test_errs;
int                 tests_run;
int                 tests_failed;
int                 check_count;
int                 error_count;

// Right-shift Galois step, taps 32 22 2 1
function automatic rta_pkg::word_t lfsr_next(rta_pkg::word_t s);
  rta_pkg::word_t n;
  n = s >> 1;
  if (s[0]) begin
    n = n ^ 32'h8020_0003;
  end
  return n;
endfunction

// One LFSR step per bit taken
function automatic rta_pkg::word_t rand_bits(int nbits);
  rta_pkg::word_t r;
  r = '0;
  for (int i = 0; i < nbits; i++) begin
    r = {r[30:0], lfsr_state[0]};
    lfsr_state = lfsr_next(lfsr_state);
  end
  return r;
endfunction

// Lowest triangle whose box holds the pixel, else a miss
function automatic rta_pkg::hit_t expected_hit(int pix, int tcnt);
  rta_pkg::hit_t  r;
  rta_pkg::coord_t x;
  rta_pkg::coord_t y;
  r = '0;
  x = rta_pkg::coord_t'(pix % 16);
  y = rta_pkg::coord_t'(pix / 16);
  for (int i = 0; i < tcnt; i++) begin
    if (!r.hit && x >= tri_model[i].x_min && x <= tri_model[i].x_max &&
        y >= tri_model[i].y_min && y <= tri_model[i].y_max) begin
      r.hit    = 1'b1;
      r.tri_id = rta_pkg::tri_id_t'(i);
    end
  end
  return r;
endfunction

// ======================================================================
// Compare tasks and per-test bookkeeping
// ======================================================================

task automatic check_word(string what, rta_pkg::word_t exp, rta_pkg::word_t act);
  check_count++;
  if (exp !== act) begin
    error_count++;
    test_errs++;
    $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
  end
endtask

task automatic check_hit(string what, rta_pkg::hit_t exp, rta_pkg::hit_t act);
  check_count++;
  if (exp !== act) begin
    error_count++;
    test_errs++;
    $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
  end
endtask

task automatic begin_test(string name);
  cur_test  = name;
  test_errs = 0;
endtask

task automatic end_test();
  tests_run++;
  if (test_errs != 0) begin
    tests_failed++;
  end
  $display("test %-14s %s", cur_test, (test_errs == 0) ? "ok" : "failed");
endtask

`endif

// File: verification/rta_tb.sv
// Testbench for the ray-cast slice
// Loads random scenes over Wishbone and checks every pixel result
`include "rta_macros.svh"

module rta_tb;

  localparam int ACK_WAIT  = 16;
  localparam int POLL_WAIT = 20000;

  logic             clk;
  logic             rst_n;
  logic             cyc;
  logic             stb;
  logic             we;
  rta_pkg::wb_adr_t adr;
  rta_pkg::word_t   dat_w;
  rta_pkg::word_t   dat_r;
  logic             ack;
  int               done_pulses;

  `include "rta_tb_model.svh"

  rta rta_inst (
    .clk(clk), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .dat_w(dat_w), .dat_r(dat_r), .ack(ack)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Counts the final result write of each run
  always @(negedge clk) begin
    if (rst_n && rta_inst.last_done) begin
      done_pulses++;
    end
  end

  task automatic abort_run(string why);
    $display("run stopped: %s", why);
    $display(">>> FAIL");
    $finish;
  endtask

  // ====================================================================
  // Wishbone classic cycles
  // ====================================================================

  task automatic bus_cycle(rta_pkg::wb_adr_t a, logic wr, rta_pkg::word_t d,
                           output rta_pkg::word_t rd);
    int n;
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    dat_w <= d;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ack && n < ACK_WAIT);
    if (!ack) begin
      abort_run($sformatf("no ack from address %h", a));
    end else begin
      // Read data is valid alongside ack
      rd = dat_r;
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
    end
  endtask

  task automatic bus_write(rta_pkg::wb_adr_t a, rta_pkg::word_t d);
    rta_pkg::word_t unused;
    bus_cycle(a, 1'b1, d, unused);
  endtask

  task automatic bus_read(rta_pkg::wb_adr_t a, output rta_pkg::word_t d);
    bus_cycle(a, 1'b0, '0, d);
  endtask

  // Poll STATUS until done
  task automatic wait_done();
    rta_pkg::word_t s;
    int n;
    n = 0;
    do begin
      bus_read(`RTA_ADR_STATUS, s);
      n++;
    end while (!s[1] && n < POLL_WAIT);
    if (!s[1]) begin
      abort_run("status done never set");
    end
  endtask

  // ====================================================================
  // Scene and run helpers
  // ====================================================================

  // Random boxes in all slots with some spilling past the image edge
  task automatic load_scene();
    rta_pkg::triangle_t t;
    for (int i = 0; i < `RTA_TRI_DEPTH; i++) begin
      t.x_min = rta_pkg::coord_t'(rand_bits(4));
      t.x_max = t.x_min + rta_pkg::coord_t'(rand_bits(3));
      t.y_min = rta_pkg::coord_t'(rand_bits(4));
      t.y_max = t.y_min + rta_pkg::coord_t'(rand_bits(3));
      tri_model[i] = t;
      bus_write(rta_pkg::wb_adr_t'(`RTA_ADR_TRI_BASE + i), rta_pkg::word_t'(t));
    end
  endtask

  task automatic start_run(int pix, int tcnt);
    bus_write(`RTA_ADR_PIX_COUNT, pix);
    bus_write(`RTA_ADR_TRI_COUNT, tcnt);
    done_pulses = 0;
    bus_write(`RTA_ADR_CTRL, 32'h1);
  endtask

  task automatic finish_run(int pix, int tcnt);
    rta_pkg::word_t d;
    wait_done();
    check_word("last result pulses", 32'd1, done_pulses);
    bus_read(`RTA_ADR_STATUS, d);
    check_word("status after run", 32'h2, d);
    for (int p = 0; p < pix; p++) begin
      res_model[p] = expected_hit(p, tcnt);
    end
    // Whole image where pixels past the range hold older values
    for (int p = 0; p < `RTA_PIX_DEPTH; p++) begin
      bus_read(rta_pkg::wb_adr_t'(`RTA_ADR_RES_BASE + p), d);
      check_hit($sformatf("pixel %0d", p), res_model[p], rta_pkg::hit_t'(d[6:0]));
    end
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================

  initial begin
    rta_pkg::word_t d;
    rta_pkg::word_t v;
    int tcnt;
    int pix;
    rst_n <= 1'b0;
    cyc   <= 1'b0;
    stb   <= 1'b0;
    we    <= 1'b0;
    adr   <= '0;
    dat_w <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    begin_test("registers");
    bus_read(`RTA_ADR_STATUS, d);
    check_word("status at reset", 32'h0, d);
    v = rand_bits(9);
    bus_write(`RTA_ADR_PIX_COUNT, v);
    bus_read(`RTA_ADR_PIX_COUNT, d);
    check_word("pix_count", v, d);
    v = rand_bits(9);
    bus_write(`RTA_ADR_TRI_COUNT, v);
    bus_read(`RTA_ADR_TRI_COUNT, d);
    check_word("tri_count", v, d);
    bus_read(10'h004, d);
    check_word("unmapped word", 32'h0, d);
    end_test();

    begin_test("empty_scene");
    load_scene();
    start_run(`RTA_PIX_DEPTH, 0);
    finish_run(`RTA_PIX_DEPTH, 0);
    end_test();

    begin_test("random_scene");
    load_scene();
    tcnt = rand_bits(6) + 1;
    start_run(`RTA_PIX_DEPTH, tcnt);
    finish_run(`RTA_PIX_DEPTH, tcnt);
    end_test();

    begin_test("partial_run");
    load_scene();
    tcnt = rand_bits(6) + 1;
    pix  = rand_bits(8);
    if (pix == 0) begin
      pix = 1;
    end
    start_run(pix, tcnt);
    finish_run(pix, tcnt);
    end_test();

    begin_test("busy_go");
    load_scene();
    tcnt = rand_bits(6) + 1;
    start_run(`RTA_PIX_DEPTH, tcnt);
    bus_read(`RTA_ADR_STATUS, d);
    check_word("status while busy", 32'h1, d);
    // Second go lands mid-run
    bus_write(`RTA_ADR_CTRL, 32'h1);
    bus_read(`RTA_ADR_STATUS, d);
    check_word("status after extra go", 32'h1, d);
    finish_run(`RTA_PIX_DEPTH, tcnt);
    end_test();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+logic
+incdir+verification
logic/rta_pkg.sv
logic/mmio_wb_slave.sv
logic/command_processor.sv
logic/mem_triangle.sv
logic/tri_scan.sv
logic/mem_result.sv
logic/rta.sv
verification/rta_tb.sv
